// File: source/raster_pkg.sv
package raster_pkg;

    // ------------------------------------------------------------------------
    // Screen and fragment geometry
    // ------------------------------------------------------------------------
    localparam int SCREEN_W  = 16;
    localparam int SCREEN_H  = 8;
    localparam int PIX_COUNT = SCREEN_W * SCREEN_H;
    localparam int PIX_W     = $clog2(PIX_COUNT);

    localparam int COORD_W = 8;
    localparam int DEPTH_W = 32;               // Smaller is closer
    localparam int COLOR_W = 8;

    // Packed as {posx, posy, depth, color}, posx at the top
    localparam int FRAG_W = 2 * COORD_W + DEPTH_W + COLOR_W;

    // ------------------------------------------------------------------------
    // Address map and clear value
    // ------------------------------------------------------------------------
    localparam int unsigned DEPTH_BASE = 32'h0000_1000;  // One word per pixel
    localparam int unsigned COLOR_BASE = 32'h0000_0000;  // One byte per pixel

    localparam logic [DEPTH_W-1:0] DEPTH_FAR = '1;

    // Fragment FIFO
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

endpackage

// File: source/bus_pkg.sv
package bus_pkg;

    // ------------------------------------------------------------------------
    // Four-phase req/ack memory bus
    // ------------------------------------------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SIZE_W = 2;

    // Direction, carried on rw
    localparam logic BUS_READ  = 1'b0;
    localparam logic BUS_WRITE = 1'b1;

    // Access size
    localparam logic [SIZE_W-1:0] BUS_SIZE_BYTE = 2'b00;
    localparam logic [SIZE_W-1:0] BUS_SIZE_WORD = 2'b10;

    // Byte write uses the low lane of wdata,
    // the address picks the byte in memory

endpackage

// File: source/fragment_fifo.sv
`timescale 1ns/1ps

module fragment_fifo
    import raster_pkg::*;
(
    input  logic              clk_i,
    input  logic              nrst_i,

    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  logic [FRAG_W-1:0] in_data_i,

    output logic              out_valid_o,
    input  logic              out_ready_i,
    output logic [FRAG_W-1:0] out_data_o
);

    logic [FRAG_W-1:0]     mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr, rd_ptr;
    logic [FIFO_CNT_W-1:0] count, count_next;
    logic                  ready_q;
    logic                  push, pop;

    assign push = in_valid_i & in_ready_o;
    assign pop  = out_valid_o & out_ready_i;

    assign count_next = count + FIFO_CNT_W'(push) - FIFO_CNT_W'(pop);

    assign in_ready_o  = ready_q;              // Registered, low through reset
    assign out_valid_o = (count != '0);
    assign out_data_o  = mem[rd_ptr];

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            ready_q <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;       // Wraps, depth is a power of two
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count   <= count_next;
            ready_q <= (count_next != FIFO_CNT_W'(FIFO_DEPTH));
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push)
            mem[wr_ptr] <= in_data_i;
    end

endmodule

// File: source/fragment_writer.sv
`timescale 1ns/1ps

module fragment_writer
    import raster_pkg::*;
    import bus_pkg::*;
(
    input  logic              clk_i,
    input  logic              nrst_i,

    // Fragment stream
    input  logic              frag_valid_i,
    output logic              frag_ready_o,
    input  logic [FRAG_W-1:0] frag_data_i,

    // Memory bus master
    output logic              req_o,
    output logic [ADDR_W-1:0] addr_o,
    output logic              rw_o,
    output logic [SIZE_W-1:0] size_o,
    output logic [DATA_W-1:0] wdata_o,
    input  logic              ack_i,
    input  logic [DATA_W-1:0] rdata_i
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_REQ,                             // Depth read
        ST_RD_WAIT,
        ST_DW_REQ,                             // Depth write
        ST_DW_WAIT,
        ST_CW_REQ,                             // Color write
        ST_CW_WAIT
    } state_t;

    state_t state;

    logic [COORD_W-1:0] in_x, in_y;
    logic [DEPTH_W-1:0] in_depth;
    logic [COLOR_W-1:0] in_color;

    logic [PIX_W-1:0]   pix_q;
    logic [DEPTH_W-1:0] depth_q;
    logic [COLOR_W-1:0] color_q;
    logic [DEPTH_W-1:0] rd_depth_q;

    logic accept;
    logic depth_pass;

    assign {in_x, in_y, in_depth, in_color} = frag_data_i;

    assign frag_ready_o = (state == ST_IDLE);
    assign accept       = frag_valid_i & frag_ready_o;

    // Strictly greater, so a tie keeps the stored pixel
    assign depth_pass = (rd_depth_q > depth_q);

    // ------------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept)
                        state <= ST_RD_REQ;
                end
                ST_RD_REQ: begin
                    if (ack_i)
                        state <= ST_RD_WAIT;
                end
                ST_RD_WAIT: begin
                    if (!ack_i)
                        state <= depth_pass ? ST_DW_REQ : ST_IDLE;
                end
                ST_DW_REQ: begin
                    if (ack_i)
                        state <= ST_DW_WAIT;
                end
                ST_DW_WAIT: begin
                    if (!ack_i)
                        state <= ST_CW_REQ;
                end
                ST_CW_REQ: begin
                    if (ack_i)
                        state <= ST_CW_WAIT;
                end
                ST_CW_WAIT: begin
                    if (!ack_i)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Fragment and read data capture
    always_ff @(posedge clk_i) begin
        if (accept) begin
            pix_q   <= PIX_W'(in_y * SCREEN_W + in_x);
            depth_q <= in_depth;
            color_q <= in_color;
        end
        if (state == ST_RD_REQ && ack_i)
            rd_depth_q <= rdata_i[DEPTH_W-1:0];
    end

    // ------------------------------------------------------------------------
    // Bus fields, fixed for the whole of each phase
    // ------------------------------------------------------------------------
    assign req_o = (state == ST_RD_REQ) || (state == ST_DW_REQ) || (state == ST_CW_REQ);

    always_comb begin
        addr_o  = ADDR_W'(DEPTH_BASE + 4 * pix_q);
        rw_o    = BUS_READ;
        size_o  = BUS_SIZE_WORD;
        wdata_o = DATA_W'(depth_q);
        if (state == ST_DW_REQ || state == ST_DW_WAIT) begin
            rw_o = BUS_WRITE;
        end else if (state == ST_CW_REQ || state == ST_CW_WAIT) begin
            addr_o  = ADDR_W'(COLOR_BASE + pix_q);
            rw_o    = BUS_WRITE;
            size_o  = BUS_SIZE_BYTE;
            wdata_o = DATA_W'(color_q);        // Low byte lane
        end
    end

endmodule

// File: source/depth_clear.sv
`timescale 1ns/1ps

module depth_clear
    import raster_pkg::*;
    import bus_pkg::*;
(
    input  logic              clk_i,
    input  logic              nrst_i,

    input  logic              start_i,
    output logic              busy_o,

    // Write-only bus master, always a word write
    output logic              req_o,
    output logic [ADDR_W-1:0] addr_o,
    output logic [DATA_W-1:0] wdata_o,
    input  logic              ack_i
);

    logic [PIX_W-1:0] pix;
    logic             wait_q;                  // Ack seen, waiting for it to fall

    assign addr_o  = ADDR_W'(DEPTH_BASE + 4 * pix);
    assign wdata_o = DATA_W'(DEPTH_FAR);

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            busy_o <= 1'b0;
            req_o  <= 1'b0;
            wait_q <= 1'b0;
            pix    <= '0;
        end else if (!busy_o) begin
            if (start_i) begin                 // Start while busy is dropped
                busy_o <= 1'b1;
                req_o  <= 1'b1;
                pix    <= '0;
            end
        end else if (req_o) begin
            if (ack_i) begin
                req_o  <= 1'b0;
                wait_q <= 1'b1;
            end
        end else if (wait_q && !ack_i) begin
            wait_q <= 1'b0;
            if (pix == PIX_W'(PIX_COUNT - 1)) begin
                busy_o <= 1'b0;                // Last word written
            end else begin
                pix   <= pix + 1'b1;
                req_o <= 1'b1;
            end
        end
    end

endmodule

// File: source/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter
    import bus_pkg::*;
(
    input  logic              clk_i,
    input  logic              nrst_i,

    // Fragment writer
    input  logic              wr_req_i,
    input  logic [ADDR_W-1:0] wr_addr_i,
    input  logic              wr_rw_i,
    input  logic [SIZE_W-1:0] wr_size_i,
    input  logic [DATA_W-1:0] wr_wdata_i,
    output logic              wr_ack_o,
    output logic [DATA_W-1:0] wr_rdata_o,

    // Depth clear
    input  logic              clr_req_i,
    input  logic [ADDR_W-1:0] clr_addr_i,
    input  logic [DATA_W-1:0] clr_wdata_i,
    output logic              clr_ack_o,

    // Memory port
    output logic              mem_req_o,
    output logic [ADDR_W-1:0] mem_addr_o,
    output logic              mem_rw_o,
    output logic [SIZE_W-1:0] mem_size_o,
    output logic [DATA_W-1:0] mem_wdata_o,
    input  logic              mem_ack_i,
    input  logic [DATA_W-1:0] mem_rdata_i
);

    logic gnt_valid_q;
    logic gnt_clr_q;
    logic ack_q;
    logic sel_clr;

    // Locked grant wins, otherwise the clear engine has priority
    assign sel_clr = gnt_valid_q ? gnt_clr_q : clr_req_i;

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            gnt_valid_q <= 1'b0;
            gnt_clr_q   <= 1'b0;
            ack_q       <= 1'b0;
        end else begin
            ack_q <= mem_ack_i;
            if (!gnt_valid_q) begin
                if (clr_req_i || wr_req_i) begin
                    gnt_valid_q <= 1'b1;
                    gnt_clr_q   <= clr_req_i;
                end
            end else if (ack_q && !mem_ack_i) begin
                gnt_valid_q <= 1'b0;           // Four-phase cycle done
            end
        end
    end

    // ------------------------------------------------------------------------
    // Routing
    // ------------------------------------------------------------------------
    assign mem_req_o   = sel_clr ? clr_req_i     : wr_req_i;
    assign mem_addr_o  = sel_clr ? clr_addr_i    : wr_addr_i;
    assign mem_rw_o    = sel_clr ? BUS_WRITE     : wr_rw_i;
    assign mem_size_o  = sel_clr ? BUS_SIZE_WORD : wr_size_i;
    assign mem_wdata_o = sel_clr ? clr_wdata_i   : wr_wdata_i;

    assign wr_ack_o   = mem_ack_i & ~sel_clr;
    assign wr_rdata_o = sel_clr ? '0 : mem_rdata_i;
    assign clr_ack_o  = mem_ack_i & sel_clr;

endmodule

// File: source/raster_backend.sv
`timescale 1ns/1ps

module raster_backend
    import raster_pkg::*;
    import bus_pkg::*;
(
    input  logic               clk_i,
    input  logic               nrst_i,

    // Fragment stream
    input  logic               frag_valid_i,
    output logic               frag_ready_o,
    input  logic [COORD_W-1:0] frag_x_i,
    input  logic [COORD_W-1:0] frag_y_i,
    input  logic [DEPTH_W-1:0] frag_depth_i,
    input  logic [COLOR_W-1:0] frag_color_i,

    // Clear control
    input  logic               clear_start_i,
    output logic               clear_busy_o,

    // Memory port
    output logic               mem_req_o,
    output logic [ADDR_W-1:0]  mem_addr_o,
    output logic               mem_rw_o,
    output logic [SIZE_W-1:0]  mem_size_o,
    output logic [DATA_W-1:0]  mem_wdata_o,
    input  logic               mem_ack_i,
    input  logic [DATA_W-1:0]  mem_rdata_i
);

    logic [FRAG_W-1:0] fifo_data;
    logic              fifo_valid, fifo_ready;
    logic              wr_valid, wr_idle;

    logic              wr_req, wr_rw, wr_ack;
    logic [ADDR_W-1:0] wr_addr;
    logic [SIZE_W-1:0] wr_size;
    logic [DATA_W-1:0] wr_wdata, wr_rdata;

    logic              clr_req, clr_req_gated, clr_ack;
    logic [ADDR_W-1:0] clr_addr;
    logic [DATA_W-1:0] clr_wdata;

    // No new fragment starts while a clear runs
    assign wr_valid   = fifo_valid & ~clear_busy_o;
    assign fifo_ready = wr_idle & ~clear_busy_o;

    // A fragment already in flight finishes before the first clear write
    assign clr_req_gated = clr_req & wr_idle;

    fragment_fifo u_fifo (
        .clk_i       (clk_i),
        .nrst_i      (nrst_i),
        .in_valid_i  (frag_valid_i),
        .in_ready_o  (frag_ready_o),
        .in_data_i   ({frag_x_i, frag_y_i, frag_depth_i, frag_color_i}),
        .out_valid_o (fifo_valid),
        .out_ready_i (fifo_ready),
        .out_data_o  (fifo_data)
    );

    fragment_writer u_writer (
        .clk_i        (clk_i),
        .nrst_i       (nrst_i),
        .frag_valid_i (wr_valid),
        .frag_ready_o (wr_idle),
        .frag_data_i  (fifo_data),
        .req_o        (wr_req),
        .addr_o       (wr_addr),
        .rw_o         (wr_rw),
        .size_o       (wr_size),
        .wdata_o      (wr_wdata),
        .ack_i        (wr_ack),
        .rdata_i      (wr_rdata)
    );

    depth_clear u_clear (
        .clk_i   (clk_i),
        .nrst_i  (nrst_i),
        .start_i (clear_start_i),
        .busy_o  (clear_busy_o),
        .req_o   (clr_req),
        .addr_o  (clr_addr),
        .wdata_o (clr_wdata),
        .ack_i   (clr_ack)
    );

    bus_arbiter u_arbiter (
        .clk_i       (clk_i),
        .nrst_i      (nrst_i),
        .wr_req_i    (wr_req),
        .wr_addr_i   (wr_addr),
        .wr_rw_i     (wr_rw),
        .wr_size_i   (wr_size),
        .wr_wdata_i  (wr_wdata),
        .wr_ack_o    (wr_ack),
        .wr_rdata_o  (wr_rdata),
        .clr_req_i   (clr_req_gated),
        .clr_addr_i  (clr_addr),
        .clr_wdata_i (clr_wdata),
        .clr_ack_o   (clr_ack),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_rw_o    (mem_rw_o),
        .mem_size_o  (mem_size_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i)
    );

endmodule

// File: dv/raster_backend_props.sv
`timescale 1ns/1ps

module raster_backend_props
    import raster_pkg::*;
    import bus_pkg::*;
(
    input logic               clk_i,
    input logic               nrst_i,
    input logic               frag_valid_i,
    input logic               frag_ready_o,
    input logic [COORD_W-1:0] frag_x_i,
    input logic [COORD_W-1:0] frag_y_i,
    input logic [DEPTH_W-1:0] frag_depth_i,
    input logic [COLOR_W-1:0] frag_color_i,
    input logic               mem_req_o,
    input logic [ADDR_W-1:0]  mem_addr_o,
    input logic               mem_rw_o,
    input logic [SIZE_W-1:0]  mem_size_o,
    input logic [DATA_W-1:0]  mem_wdata_o,
    input logic               mem_ack_i
);

    // ------------------------------------------------------------------------
    // Four-phase bus
    // ------------------------------------------------------------------------
    req_held: assert property (@(posedge clk_i) disable iff (!nrst_i)
        mem_req_o && !mem_ack_i |=> mem_req_o)
        else $error("mem_req_o dropped before ack");

    fields_stable: assert property (@(posedge clk_i) disable iff (!nrst_i)
        mem_req_o && !mem_ack_i |=>
            $stable({mem_addr_o, mem_rw_o, mem_size_o, mem_wdata_o}))
        else $error("request fields changed while waiting for ack");

    // Req is raised on an edge, so ack is judged at that same edge
    no_rise_on_ack: assert property (@(posedge clk_i) disable iff (!nrst_i)
        $rose(mem_req_o) |-> !$past(mem_ack_i))
        else $error("mem_req_o rose while ack was high");

    // Fragment stream held until accepted
    valid_held: assert property (@(posedge clk_i) disable iff (!nrst_i)
        frag_valid_i && !frag_ready_o |=>
            frag_valid_i && $stable({frag_x_i, frag_y_i, frag_depth_i, frag_color_i}))
        else $error("fragment changed or dropped while stalled");

endmodule

bind raster_backend raster_backend_props u_props (
    .clk_i        (clk_i),
    .nrst_i       (nrst_i),
    .frag_valid_i (frag_valid_i),
    .frag_ready_o (frag_ready_o),
    .frag_x_i     (frag_x_i),
    .frag_y_i     (frag_y_i),
    .frag_depth_i (frag_depth_i),
    .frag_color_i (frag_color_i),
    .mem_req_o    (mem_req_o),
    .mem_addr_o   (mem_addr_o),
    .mem_rw_o     (mem_rw_o),
    .mem_size_o   (mem_size_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_ack_i    (mem_ack_i)
);

// File: dv/raster_backend_tb.sv
`timescale 1ns/1ps

module raster_backend_tb
    import raster_pkg::*;
    import bus_pkg::*;
;

    localparam int N_FRAG  = 200;
    localparam int HALF    = N_FRAG / 2;
    localparam int TIMEOUT = N_FRAG * 40 + 2 * PIX_COUNT * 10;

    logic clk_i = 1'b0;
    logic nrst_i;
    logic frag_valid_i, frag_ready_o;
    logic [COORD_W-1:0] frag_x_i, frag_y_i;
    logic [DEPTH_W-1:0] frag_depth_i;
    logic [COLOR_W-1:0] frag_color_i;
    logic clear_start_i, clear_busy_o;
    logic mem_req_o, mem_rw_o, mem_ack_i;
    logic [ADDR_W-1:0] mem_addr_o;
    logic [SIZE_W-1:0] mem_size_o;
    logic [DATA_W-1:0] mem_wdata_o, mem_rdata_i;

    // Memory model and bus counters
    logic [DEPTH_W-1:0] depth_mem [PIX_COUNT];
    logic [COLOR_W-1:0] color_mem [PIX_COUNT];
    int clr_hits [PIX_COUNT];
    int reads, depth_writes, color_writes, far_writes, reads_at_clear;

    // Stimulus and reference image
    logic [COORD_W-1:0] fx [N_FRAG];
    logic [COORD_W-1:0] fy [N_FRAG];
    logic [DEPTH_W-1:0] fd [N_FRAG];
    logic [COLOR_W-1:0] fc [N_FRAG];
    logic [DEPTH_W-1:0] ref_depth [PIX_COUNT];
    logic [COLOR_W-1:0] ref_color [PIX_COUNT];
    int ref_pass, pushed, errors, passed, failed, cycles, mark, clear_pos;
    bit stall_seen;
    logic [31:0] stim_lfsr = 32'd1;
    logic [31:0] mem_lfsr  = 32'd1;

    raster_backend DUT (.*);

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic int stim_bits(int n);
        int v = 0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            v = (v << 1) | stim_lfsr[0];
        end
        return v;
    endfunction

    function automatic int delay_bits(int n);
        int v = 0;
        for (int i = 0; i < n; i++) begin
            mem_lfsr = lfsr_next(mem_lfsr);
            v = (v << 1) | mem_lfsr[0];
        end
        return v;
    endfunction

    task automatic tick();
        @(posedge clk_i);
        #1;
    endtask

    // ------------------------------------------------------------------------
    // Memory slave with random ack delay
    // ------------------------------------------------------------------------
    task automatic mem_access();
        int p;
        bit in_depth, in_color;
        in_depth = (mem_addr_o >= DEPTH_BASE) && (mem_addr_o < DEPTH_BASE + 4 * PIX_COUNT);
        in_color = (mem_addr_o >= COLOR_BASE) && (mem_addr_o < COLOR_BASE + PIX_COUNT);
        if (mem_rw_o == BUS_READ) begin
            reads++;
            p = (mem_addr_o - DEPTH_BASE) >> 2;
            mem_rdata_i = in_depth ? DATA_W'(depth_mem[p]) : '0;
        end else begin
            assert (in_depth || in_color) else begin
                errors++;
                $display("Memory write to address %h is out of range", mem_addr_o);
            end
            if (in_depth && mem_size_o == BUS_SIZE_WORD) begin
                p = (mem_addr_o - DEPTH_BASE) >> 2;
                depth_mem[p] = mem_wdata_o[DEPTH_W-1:0];
                if (mem_wdata_o[DEPTH_W-1:0] == DEPTH_FAR) begin
                    if (far_writes == 0)
                        reads_at_clear = reads;   // Clear position in the stream
                    far_writes++;
                    clr_hits[p]++;
                end else begin
                    depth_writes++;
                end
            end else if (in_color && mem_size_o == BUS_SIZE_BYTE) begin
                color_mem[mem_addr_o - COLOR_BASE] = mem_wdata_o[COLOR_W-1:0];
                color_writes++;
            end
        end
    endtask

    always begin
        int d;
        tick();
        if (nrst_i && mem_req_o && !mem_ack_i) begin
            d = delay_bits(2);
            repeat (d) tick();
            mem_access();
            mem_ack_i = 1'b1;
            do tick(); while (mem_req_o);
            mem_ack_i   = 1'b0;
            mem_rdata_i = '0;
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus and checks
    // ------------------------------------------------------------------------
    task automatic send_frag(int i);
        frag_valid_i = 1'b1;
        frag_x_i     = fx[i];
        frag_y_i     = fy[i];
        frag_depth_i = fd[i];
        frag_color_i = fc[i];
        while (!frag_ready_o) begin
            stall_seen = 1'b1;                 // FIFO full
            tick();
        end
        tick();
        frag_valid_i = 1'b0;
        pushed++;
    endtask

    task automatic pulse_clear();
        clear_start_i = 1'b1;
        tick();
        clear_start_i = 1'b0;
        assert (clear_busy_o) else begin
            errors++;
            $display("Error at %0t: clear_busy_o did not rise after start", $time);
        end
        while (clear_busy_o)
            tick();
    endtask

    task automatic wait_quiet(int n_reads);
        int quiet = 0;
        while (reads < n_reads)
            tick();
        while (quiet < 8) begin
            tick();
            quiet = (!mem_req_o && !mem_ack_i) ? quiet + 1 : 0;
        end
    endtask

    task automatic clear_counters();
        reads = 0;
        depth_writes = 0;
        color_writes = 0;
        far_writes = 0;
        for (int p = 0; p < PIX_COUNT; p++)
            clr_hits[p] = 0;
    endtask

    task automatic apply_ref(int i);
        int p;
        p = fy[i] * SCREEN_W + fx[i];
        if (ref_depth[p] > fd[i]) begin       // Tie keeps the earlier fragment
            ref_depth[p] = fd[i];
            ref_color[p] = fc[i];
            ref_pass++;
        end
    endtask

    task automatic check_clear();
        for (int p = 0; p < PIX_COUNT; p++)
            assert (clr_hits[p] == 1) else begin
                errors++;
                $display("Error at %0t: pixel %0d cleared %0d times", $time, p, clr_hits[p]);
            end
    endtask

    task automatic check_image(bit with_depth);
        for (int p = 0; p < PIX_COUNT; p++) begin
            assert (color_mem[p] == ref_color[p]) else begin
                errors++;
                $display("Error at %0t: pixel %0d color %h, expected %h",
                         $time, p, color_mem[p], ref_color[p]);
            end
            if (with_depth)
                assert (depth_mem[p] == ref_depth[p]) else begin
                    errors++;
                    $display("Error at %0t: pixel %0d depth %h, expected %h",
                             $time, p, depth_mem[p], ref_depth[p]);
                end
        end
    endtask

    task automatic check_counts(int n);
        assert (reads == n && depth_writes == ref_pass && color_writes == ref_pass) else begin
            errors++;
            $display("Error at %0t: %0d reads %0d depth %0d color writes, expected %0d %0d %0d",
                     $time, reads, depth_writes, color_writes, n, ref_pass, ref_pass);
        end
    endtask

    task automatic report_test(string name);
        if (errors == mark) begin
            passed++;
            $display("[%0t] %s: pass", $time, name);
        end else begin
            failed++;
            $display("[%0t] %s: fail", $time, name);
        end
        mark = errors;
    endtask

    initial begin
        nrst_i = 1'b0;
        frag_valid_i = 1'b0;
        frag_x_i = '0;
        frag_y_i = '0;
        frag_depth_i = '0;
        frag_color_i = '0;
        clear_start_i = 1'b0;
        mem_ack_i = 1'b0;
        mem_rdata_i = '0;
        for (int i = 0; i < N_FRAG; i++) begin
            fx[i] = COORD_W'(stim_bits(4));
            fy[i] = COORD_W'(stim_bits(3));
            fd[i] = DEPTH_W'(stim_bits(4));    // Few depth values, many ties
            fc[i] = COLOR_W'(stim_bits(8));
        end
        for (int p = 0; p < PIX_COUNT; p++) begin
            depth_mem[p] = 32'h5A00_0000 ^ (p * 32'h0001_0203);
            color_mem[p] = COLOR_W'(p * 7 + 3) ^ 8'hC3;
            ref_color[p] = color_mem[p];
        end
        clear_counters();

        repeat (3) @(posedge clk_i);
        #1;
        assert (!mem_req_o && !frag_ready_o && !clear_busy_o) else begin
            errors++;
            $display("Error at %0t: outputs not low in reset", $time);
        end
        nrst_i = 1'b1;
        tick();

        // 1: first clear
        pulse_clear();
        check_clear();
        for (int p = 0; p < PIX_COUNT; p++)
            ref_depth[p] = DEPTH_FAR;
        check_image(1'b1);
        report_test("1 reset and first clear");

        // 2 and 3: first half against the cleared buffer
        clear_counters();
        ref_pass = 0;
        for (int i = 0; i < HALF; i++)
            send_frag(i);
        wait_quiet(HALF);
        for (int i = 0; i < HALF; i++)
            apply_ref(i);
        check_image(1'b0);
        report_test("2 color image after first half");
        check_counts(HALF);
        report_test("3 depth test write counts");

        // 4: second clear while fragments are queued
        clear_counters();
        fork
            for (int i = HALF; i < N_FRAG; i++)
                send_frag(i);
            begin
                while (pushed < HALF + 6)
                    tick();
                pulse_clear();
            end
        join
        wait_quiet(HALF);
        clear_pos = reads_at_clear;
        for (int i = HALF; i < HALF + clear_pos; i++)
            apply_ref(i);
        for (int p = 0; p < PIX_COUNT; p++)
            ref_depth[p] = DEPTH_FAR;
        for (int i = HALF + clear_pos; i < N_FRAG; i++)
            apply_ref(i);
        check_clear();
        check_image(1'b1);
        report_test("4 second clear with queued fragments");

        // 5: back-pressure seen and nothing lost
        assert (stall_seen) else begin
            errors++;
            $display("FIFO never filled and frag_ready_o never dropped");
        end
        assert (reads == HALF) else begin
            errors++;
            $display("Error at %0t: %0d fragments read in the second half, expected %0d",
                     $time, reads, HALF);
        end
        report_test("5 back-pressure");

        $display("Tests passed: %0d, failed: %0d", passed, failed);
        if (failed == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: src.f
source/raster_pkg.sv
source/bus_pkg.sv
source/fragment_fifo.sv
source/fragment_writer.sv
source/depth_clear.sv
source/bus_arbiter.sv
source/raster_backend.sv
dv/raster_backend_props.sv
dv/raster_backend_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= raster_backend_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
